/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/cpu_ctrl_ifs.sv
hw/unified_ram.sv
hw/instr_decoder.sv
hw/fetch_unit.sv
hw/datapath.sv
hw/cpu_controller.sv
hw/cpu_top.sv
test/cpu_props.sv
test/cpu_tb.sv

/* hw/cpu_controller.sv */
module cpu_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_isa_pkg::instr_kind_t kind,
    output cpu_ctrl_pkg::reg_sel_t   reg_sel,
    output logic                     halted,
    fetch_ctrl_if.ctrl               fetch_ctl,
    datapath_ctrl_if.ctrl            dp_ctl
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    cpu_state_t state;
    cpu_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state <= S_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_FETCH:  next_state = S_DECODE;
            S_DECODE: begin
                case (kind)
                    KIND_MOV_IMM:             next_state = S_WRITEBACK;
                    KIND_MOV_REG, KIND_MVN:   next_state = S_READ_B;
                    KIND_ADD, KIND_AND:       next_state = S_READ_A;
                    KIND_LDR:                 next_state = S_READ_A;
                    default:                  next_state = S_HALT;
                endcase
            end
            S_READ_A:    next_state = (kind == KIND_LDR) ? S_EXECUTE : S_READ_B;
            S_READ_B:    next_state = S_EXECUTE;
            S_EXECUTE:   next_state = (kind == KIND_LDR) ? S_MEM_ADDR : S_WRITEBACK;
            S_MEM_ADDR:  next_state = S_MEM_READ;
            S_MEM_READ:  next_state = S_WRITEBACK;
            S_WRITEBACK: next_state = S_FETCH;
            S_HALT:      next_state = S_HALT; // only reset leaves
            default:     next_state = S_FETCH;
        endcase
    end

    // enables follow the state
    assign fetch_ctl.load_ir   = (state == S_DECODE);
    assign fetch_ctl.load_pc   = (state == S_DECODE);
    assign fetch_ctl.load_addr = (state == S_MEM_ADDR);
    assign fetch_ctl.sel_addr  = (state != S_MEM_READ);

    assign dp_ctl.en_a = (state == S_READ_A);
    assign dp_ctl.en_b = (state == S_READ_B);
    assign dp_ctl.en_c = (state == S_EXECUTE);
    assign dp_ctl.w_en = (state == S_WRITEBACK);

    // operand muxes only matter in execute
    assign dp_ctl.sel_a = (kind == KIND_MOV_REG);
    assign dp_ctl.sel_b = (kind == KIND_LDR);

    always_comb begin
        case (kind)
            KIND_MOV_IMM: dp_ctl.wb_sel = WB_IMM8;
            KIND_LDR:     dp_ctl.wb_sel = WB_MEM;
            default:      dp_ctl.wb_sel = WB_C;
        endcase
    end

    always_comb begin
        case (state)
            S_READ_A:    reg_sel = REG_RN;
            S_READ_B:    reg_sel = REG_RM;
            S_WRITEBACK: reg_sel = (kind == KIND_MOV_IMM) ? REG_RN : REG_RD;
            default:     reg_sel = REG_RD;
        endcase
    end

    assign halted = (state == S_HALT);

endmodule

/* hw/cpu_ctrl_ifs.sv */
interface datapath_ctrl_if;
    import cpu_ctrl_pkg::*;

    logic    en_a;
    logic    en_b;
    logic    en_c;
    logic    sel_a; // 1 selects zero
    logic    sel_b; // 1 selects sximm5
    wb_sel_t wb_sel;
    logic    w_en;

    modport ctrl (output en_a, en_b, en_c, sel_a, sel_b, wb_sel, w_en);
    modport dp   (input  en_a, en_b, en_c, sel_a, sel_b, wb_sel, w_en);
endinterface

interface fetch_ctrl_if;
    logic load_ir;
    logic load_pc;
    logic load_addr;
    logic sel_addr; // 1 selects pc

    modport ctrl  (output load_ir, load_pc, load_addr, sel_addr);
    modport fetch (input  load_ir, load_pc, load_addr, sel_addr);
endinterface

/* hw/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_READ_A,
        S_READ_B,
        S_EXECUTE,
        S_MEM_ADDR,
        S_MEM_READ,
        S_WRITEBACK,
        S_HALT
    } cpu_state_t;

    typedef enum logic [1:0] {
        WB_C,
        WB_IMM8,
        WB_MEM
    } wb_sel_t;

    typedef enum logic [1:0] {
        REG_RN,
        REG_RD,
        REG_RM
    } reg_sel_t;

endpackage

/* hw/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  mem_addr_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [2:0]  opcode_t;
    typedef logic [1:0]  op_t;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL  = 2'b01,
        SH_LSR  = 2'b10,
        SH_ASR  = 2'b11
    } shift_op_t;

    // 2'b01 was subtract, not implemented
    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_AND   = 2'b10,
        ALU_NOT_B = 2'b11
    } alu_op_t;

    typedef enum logic [2:0] {
        KIND_MOV_IMM,
        KIND_MOV_REG,
        KIND_ADD,
        KIND_AND,
        KIND_MVN,
        KIND_LDR,
        KIND_HALT
    } instr_kind_t;

    localparam opcode_t OPC_ALU  = 3'b101;
    localparam opcode_t OPC_MOV  = 3'b110;
    localparam opcode_t OPC_LDR  = 3'b011;
    localparam opcode_t OPC_HALT = 3'b111;

    localparam op_t OP_MOV_IMM = 2'b10;
    localparam op_t OP_MOV_REG = 2'b00;
    localparam op_t OP_ADD     = 2'b00;
    localparam op_t OP_AND     = 2'b10;
    localparam op_t OP_MVN     = 2'b11;
    localparam op_t OP_LDR     = 2'b00;

    localparam int OPCODE_LSB = 13;
    localparam int OP_LSB     = 11;
    localparam int RN_LSB     = 8;
    localparam int RD_LSB     = 5;
    localparam int SHIFT_LSB  = 3;
    localparam int RM_LSB     = 0;
    localparam int IMM5_W     = 5;
    localparam int IMM8_W     = 8;

    localparam int MEM_WORDS = 256;

endpackage

/* hw/cpu_top.sv */
module cpu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_isa_pkg::mem_addr_t start_pc,
    input  logic                  mem_load,
    input  cpu_isa_pkg::mem_addr_t mem_addr,
    input  cpu_isa_pkg::word_t     mem_wdata,
    output cpu_isa_pkg::word_t     out,
    output logic                  halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    instr_kind_t kind;
    reg_sel_t    reg_sel;
    alu_op_t     alu_op;
    shift_op_t   shift_op;
    reg_addr_t   r_addr;
    reg_addr_t   w_addr;
    word_t       sximm5;
    word_t       sximm8;
    word_t       ir;
    word_t       rdata;
    word_t       c_value;
    mem_addr_t   ram_addr;

    datapath_ctrl_if dp_ctl ();
    fetch_ctrl_if    fetch_ctl ();

    cpu_controller i_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .kind      (kind),
        .reg_sel   (reg_sel),
        .halted    (halted),
        .fetch_ctl (fetch_ctl.ctrl),
        .dp_ctl    (dp_ctl.ctrl)
    );

    instr_decoder i_decoder (
        .ir       (ir),
        .reg_sel  (reg_sel),
        .kind     (kind),
        .alu_op   (alu_op),
        .shift_op (shift_op),
        .r_addr   (r_addr),
        .w_addr   (w_addr),
        .sximm5   (sximm5),
        .sximm8   (sximm8)
    );

    fetch_unit i_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_pc (start_pc),
        .rdata    (rdata),
        .c_value  (c_value),
        .ctl      (fetch_ctl.fetch),
        .ir       (ir),
        .ram_addr (ram_addr)
    );

    datapath i_datapath (
        .clk      (clk),
        .mdata    (rdata),
        .r_addr   (r_addr),
        .w_addr   (w_addr),
        .alu_op   (alu_op),
        .shift_op (shift_op),
        .sximm5   (sximm5),
        .sximm8   (sximm8),
        .ctl      (dp_ctl.dp),
        .c_value  (c_value)
    );

    unified_ram i_ram (
        .clk   (clk),
        .raddr (ram_addr),
        .we    (mem_load),
        .waddr (mem_addr),
        .wdata (mem_wdata),
        .rdata (rdata)
    );

    assign out = c_value;

endmodule

/* hw/datapath.sv */
module datapath (
    input  logic                   clk,
    input  cpu_isa_pkg::word_t     mdata,
    input  cpu_isa_pkg::reg_addr_t r_addr,
    input  cpu_isa_pkg::reg_addr_t w_addr,
    input  cpu_isa_pkg::alu_op_t   alu_op,
    input  cpu_isa_pkg::shift_op_t shift_op,
    input  cpu_isa_pkg::word_t     sximm5,
    input  cpu_isa_pkg::word_t     sximm8,
    datapath_ctrl_if.dp            ctl,
    output cpu_isa_pkg::word_t     c_value
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t regs [2**$bits(reg_addr_t)];
    word_t r_data;
    word_t w_data;
    word_t a_q;
    word_t b_q;
    word_t c_q;
    word_t shifted;
    word_t val_a;
    word_t val_b;
    word_t alu_out;

    always_ff @(posedge clk) begin
        if (ctl.w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    assign r_data = regs[r_addr];

    always_ff @(posedge clk) begin
        if (ctl.en_a) begin
            a_q <= r_data;
        end
        if (ctl.en_b) begin
            b_q <= r_data;
        end
        if (ctl.en_c) begin
            c_q <= alu_out;
        end
    end

    always_comb begin
        case (shift_op)
            SH_LSL:  shifted = b_q << 1;
            SH_LSR:  shifted = b_q >> 1;
            SH_ASR:  shifted = {b_q[$bits(word_t)-1], b_q[$bits(word_t)-1:1]};
            default: shifted = b_q;
        endcase
    end

    assign val_a = ctl.sel_a ? '0 : a_q;
    assign val_b = ctl.sel_b ? sximm5 : shifted;

    always_comb begin
        case (alu_op)
            ALU_AND:   alu_out = val_a & val_b;
            ALU_NOT_B: alu_out = ~val_b;
            default:   alu_out = val_a + val_b; // wraps
        endcase
    end

    always_comb begin
        case (ctl.wb_sel)
            WB_IMM8: w_data = sximm8;
            WB_MEM:  w_data = mdata;
            default: w_data = c_q;
        endcase
    end

    assign c_value = c_q;

endmodule

/* hw/fetch_unit.sv */
module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_isa_pkg::mem_addr_t start_pc,
    input  cpu_isa_pkg::word_t     rdata,
    input  cpu_isa_pkg::word_t     c_value,
    fetch_ctrl_if.fetch            ctl,
    output cpu_isa_pkg::word_t     ir,
    output cpu_isa_pkg::mem_addr_t ram_addr
);
    import cpu_isa_pkg::*;

    mem_addr_t pc;
    mem_addr_t data_addr;
    word_t     ir_q;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= start_pc;
        end else if (ctl.load_pc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.load_ir) begin
            ir_q <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.load_addr) begin
            data_addr <= c_value[$bits(mem_addr_t)-1:0]; // low byte of C
        end
    end

    // in decode the fetched word is seen before the IR holds it
    assign ir       = ctl.load_ir ? rdata : ir_q;
    assign ram_addr = ctl.sel_addr ? pc : data_addr;

endmodule

/* hw/instr_decoder.sv */
module instr_decoder (
    input  cpu_isa_pkg::word_t        ir,
    input  cpu_ctrl_pkg::reg_sel_t    reg_sel,
    output cpu_isa_pkg::instr_kind_t  kind,
    output cpu_isa_pkg::alu_op_t      alu_op,
    output cpu_isa_pkg::shift_op_t    shift_op,
    output cpu_isa_pkg::reg_addr_t    r_addr,
    output cpu_isa_pkg::reg_addr_t    w_addr,
    output cpu_isa_pkg::word_t        sximm5,
    output cpu_isa_pkg::word_t        sximm8
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    opcode_t   opcode;
    op_t       op;
    reg_addr_t rn;
    reg_addr_t rd;
    reg_addr_t rm;
    reg_addr_t reg_field;

    assign opcode = ir[OPCODE_LSB +: $bits(opcode_t)];
    assign op     = ir[OP_LSB +: $bits(op_t)];
    assign rn     = ir[RN_LSB +: $bits(reg_addr_t)];
    assign rd     = ir[RD_LSB +: $bits(reg_addr_t)];
    assign rm     = ir[RM_LSB +: $bits(reg_addr_t)];

    always_comb begin
        kind = KIND_HALT; // anything unknown stops the core
        case (opcode)
            OPC_MOV: begin
                if (op == OP_MOV_IMM) kind = KIND_MOV_IMM;
                else if (op == OP_MOV_REG) kind = KIND_MOV_REG;
            end
            OPC_ALU: begin
                case (op)
                    OP_ADD:  kind = KIND_ADD;
                    OP_AND:  kind = KIND_AND;
                    OP_MVN:  kind = KIND_MVN;
                    default: kind = KIND_HALT;
                endcase
            end
            OPC_LDR:  kind = (op == OP_LDR) ? KIND_LDR : KIND_HALT;
            OPC_HALT: kind = KIND_HALT;
            default:  kind = KIND_HALT;
        endcase
    end

    always_comb begin
        case (kind)
            KIND_AND: alu_op = ALU_AND;
            KIND_MVN: alu_op = ALU_NOT_B;
            default:  alu_op = ALU_ADD; // mov reg and ldr add to zero/imm
        endcase
    end

    assign shift_op = shift_op_t'(ir[SHIFT_LSB +: $bits(shift_op_t)]);

    always_comb begin
        case (reg_sel)
            REG_RN:  reg_field = rn;
            REG_RM:  reg_field = rm;
            default: reg_field = rd;
        endcase
    end

    assign r_addr = reg_field;
    assign w_addr = reg_field;

    assign sximm5 = {{($bits(word_t) - IMM5_W){ir[IMM5_W-1]}}, ir[IMM5_W-1:0]};
    assign sximm8 = {{($bits(word_t) - IMM8_W){ir[IMM8_W-1]}}, ir[IMM8_W-1:0]};

endmodule

/* hw/unified_ram.sv */
module unified_ram (
    input  logic                   clk,
    input  cpu_isa_pkg::mem_addr_t raddr,
    input  logic                   we,
    input  cpu_isa_pkg::mem_addr_t waddr,
    input  cpu_isa_pkg::word_t     wdata,
    output cpu_isa_pkg::word_t     rdata
);
    import cpu_isa_pkg::*;

    word_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr]; // one cycle read latency
    end

endmodule

/* test/cpu_props.sv */
module cpu_props (
    input logic                     clk,
    input logic                     rst_n,
    input cpu_ctrl_pkg::cpu_state_t state,
    input logic                     w_en,
    input logic                     load_ir
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_ctrl_pkg::*;

    // fetch then decode once reset is released
    fetch_after_reset: assert property (@(posedge clk) $fell(rst_n) |=> load_ir)
        else $error("no instruction load in the cycle after the reset fetch");

    // only reset takes the core out of halt
    halt_is_sticky: assert property (@(posedge clk)
        (state == S_HALT && !rst_n) |=> state == S_HALT)
        else $error("halt state left without reset");

    write_after_operands: assert property (@(posedge clk)
        w_en |-> $past(state) inside {S_DECODE, S_EXECUTE, S_MEM_READ})
        else $error("register write not preceded by decode, execute or mem_read");

    ir_load_after_fetch: assert property (@(posedge clk)
        load_ir |-> $past(state) == S_FETCH)
        else $error("instruction register loaded without a fetch before it");

endmodule

bind cpu_controller cpu_props i_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (state),
    .w_en    (dp_ctl.w_en),
    .load_ir (fetch_ctl.load_ir)
);

/* test/cpu_tb.sv */
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_isa_pkg::*;

    localparam int NUM_TESTS   = 150;
    localparam int RAND_INSTRS = 16;
    localparam int PROG_WORDS  = 8 + RAND_INSTRS + 1;
    localparam int LOAD_CYCLES = 300;
    localparam int EXEC_CYCLES = (PROG_WORDS + 1) * 7;
    localparam int CYCLE_LIMIT = NUM_TESTS * (LOAD_CYCLES + EXEC_CYCLES);
    localparam int HALT_HOLD   = 3;
    localparam int HALT_DELAY  = 2; // fetch and decode of the halting word

    logic      clk;
    logic      rst_n;
    mem_addr_t start_pc;
    logic      mem_load;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     out;
    logic      halted;

    logic [15:0] lfsr = 16'd82;
    int          cycle_count = 0;
    word_t       mem_model [MEM_WORDS];
    word_t       reg_model [8];
    word_t       c_model;
    logic        c_known; // C has no reset, so unknown until the first execute

    cpu_top i_cpu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_pc  (start_pc),
        .mem_load  (mem_load),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .out       (out),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1, "cycle limit reached");
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function word_t random_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_step()};
        end
        return r;
    endfunction

    function word_t shift_model(word_t b, logic [1:0] sh);
        case (sh)
            2'd1:    return {b[14:0], 1'b0};
            2'd2:    return {1'b0, b[15:1]};
            2'd3:    return {b[15], b[15:1]};
            default: return b;
        endcase
    endfunction

    task check_value(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("ERROR t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task build_program(output mem_addr_t base);
        mem_addr_t  a;
        word_t      rnd;
        word_t      instr;
        logic [2:0] pick;
        base = mem_addr_t'(random_bits(8) % 100);
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = mem_addr_t'(i);
            if (i < 128) mem_model[a] = {~a, a}; // filler below the data area
            else mem_model[a] = random_bits(16);
        end
        for (int r = 0; r < 8; r++) begin
            rnd = random_bits(8);
            mem_model[base + mem_addr_t'(r)] = {5'b11010, 3'(r), rnd[7:0]};
        end
        for (int k = 0; k < RAND_INSTRS; k++) begin
            pick = 3'(random_bits(3) % 6);
            rnd = random_bits(11);
            case (pick)
                3'd0:    instr = {5'b11010, rnd[10:0]}; // mov imm
                3'd1:    instr = {5'b11000, rnd[10:0]}; // mov reg
                3'd2:    instr = {5'b10100, rnd[10:0]}; // add
                3'd3:    instr = {5'b10110, rnd[10:0]}; // and
                3'd4:    instr = {5'b10111, rnd[10:0]}; // mvn
                default: instr = {5'b01100, rnd[10:0]}; // ldr
            endcase
            mem_model[base + mem_addr_t'(8 + k)] = instr;
        end
        rnd = random_bits(13);
        pick = 3'(random_bits(2));
        case (pick[1:0])
            2'd0:    instr = {3'b111, rnd[12:0]};
            2'd1:    instr = {3'b000, rnd[12:0]};
            2'd2:    instr = {5'b10101, rnd[10:0]}; // old subtract slot
            default: instr = {5'b11011, rnd[10:0]};
        endcase
        mem_model[base + mem_addr_t'(PROG_WORDS - 1)] = instr;
    endtask

    task load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_load  = 1'b1;
            mem_addr  = mem_addr_t'(i);
            mem_wdata = mem_model[mem_addr_t'(i)];
            @(posedge clk);
            #1;
        end
        mem_load = 1'b0;
    endtask

    // one instruction on the model, with its cycle count from fetch to the next fetch
    task automatic execute_model(input word_t w, output int cycles, output logic halt);
        logic [2:0] rn;
        logic [2:0] rd;
        word_t      b;
        rn = w[10:8];
        rd = w[7:5];
        b = shift_model(reg_model[w[2:0]], w[4:3]);
        halt = 1'b0;
        cycles = 3;
        case (w[15:11])
            5'b11010: reg_model[rn] = {{8{w[7]}}, w[7:0]};
            5'b11000: begin
                c_model = b;
                cycles = 5;
            end
            5'b10100: begin
                c_model = reg_model[rn] + b;
                cycles = 6;
            end
            5'b10110: begin
                c_model = reg_model[rn] & b;
                cycles = 6;
            end
            5'b10111: begin
                c_model = ~b;
                cycles = 5;
            end
            5'b01100: begin
                c_model = reg_model[rn] + {{11{w[4]}}, w[4:0]};
                cycles = 7;
            end
            default: halt = 1'b1;
        endcase
        if (!halt && cycles > 3) begin
            c_known = 1'b1;
            reg_model[rd] = (cycles == 7) ? mem_model[c_model[7:0]] : c_model;
        end
    endtask

    task wait_halted();
        int waited;
        waited = 0;
        while (halted !== 1'b1) begin
            if (waited >= HALT_DELAY) begin
                $display("halted still low %0d cycles after the halting fetch", HALT_DELAY);
                $display("FAIL: see errors above");
                $fatal(1, "halted did not rise");
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task run_test();
        mem_addr_t base;
        mem_addr_t pc;
        word_t     w;
        int        cycles;
        logic      done;
        build_program(base);
        rst_n = 1'b1;
        start_pc = base;
        load_memory();
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        rst_n = 1'b0;
        pc = base;
        done = 1'b0;
        while (!done) begin
            w = mem_model[pc];
            pc = pc + 8'd1;
            execute_model(w, cycles, done);
            if (!done) begin
                repeat (cycles) @(posedge clk);
                #1;
                check_value("halted", {15'b0, halted}, 16'h0000);
                if (c_known) check_value("out", out, c_model);
            end
        end
        wait_halted();
        repeat (HALT_HOLD) begin
            @(posedge clk);
            #1;
            check_value("halted", {15'b0, halted}, 16'h0001);
            if (c_known) check_value("out", out, c_model);
        end
    endtask

    initial begin
        rst_n     = 1'b1;
        start_pc  = '0;
        mem_load  = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        c_model   = '0;
        c_known   = 1'b0;
        @(posedge clk);
        #1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule
